// ==== verilog/mesh_pkg.sv ====
// ==========================================================================
// Geometry is fixed to a 4x4 mesh. Larger meshes need a wider coord_w
// ==========================================================================
package mesh_pkg;

    // Coordinate width for one mesh axis
    localparam int coord_w = 2;

    typedef logic [coord_w-1:0] t_coord;    // One X or Y position

    // Output direction at a router, also the input FIFO it lands in next
    typedef enum logic [2:0] {
        dir_north = 3'd0,
        dir_east  = 3'd1,
        dir_south = 3'd2,
        dir_west  = 3'd3,
        dir_local = 3'd4                    // Eject to the tile itself
    } t_cardinal;

endpackage

// ==== verilog/router_pkg.sv ====
// ==========================================================================
// Transaction layout shared by all ports. Field order sets the packed bits
// ==========================================================================
package router_pkg;

    // ======================================================================
    // Field widths
    // ======================================================================
    localparam int tag_w     = 8;           // Sender side transaction id
    localparam int payload_w = 16;          // Data carried end to end

    // ======================================================================
    // Tile transaction
    // ======================================================================
    // Tag sits in the top bits, payload at the bottom
    typedef struct packed {
        logic [tag_w-1:0]     tag;
        mesh_pkg::t_coord     dest_x;       // Final tile column
        mesh_pkg::t_coord     dest_y;       // Final tile row
        mesh_pkg::t_cardinal  next_tile_fifo_arb_id;  // Set by the route stage
        logic [payload_w-1:0] payload;
    } t_tile_trans;

    // Handy for sizing storage that holds whole transactions
    localparam int trans_w = $bits(t_tile_trans);

endpackage

// ==== verilog/tile_fifo.sv ====
// ==========================================================================
// Head is visible the cycle after a push into an empty FIFO. depth >= 2
// Push when full is lost unless a pop happens in the same cycle
// ==========================================================================
`timescale 1ns/1ps

module tile_fifo #(
    parameter int data_w = 8,
    parameter int depth  = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push,
    input  logic [data_w-1:0] push_data,
    input  logic              pop,
    output logic [data_w-1:0] pop_data,
    output logic              full,
    output logic              empty
);

    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);   // Must hold the value depth

    logic [data_w-1:0] mem [depth];             // Storage, no reset needed
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  count;                   // Items held
    logic              do_push;
    logic              do_pop;

    assign full  = (count == cnt_w'(depth));
    assign empty = (count == '0);

    // Qualified strobes
    assign do_pop  = pop && !empty;             // Pop on empty ignored
    assign do_push = push && (!full || do_pop); // Slot frees up on a pop

    assign pop_data = mem[rd_ptr];              // Fall-through head

    // Payload write
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // ======================================================================
    // Pointers and occupancy
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== verilog/rr_arbiter.sv ====
// ==========================================================================
// Grant is combinational from the candidates. Pointer restarts at client 0
// ==========================================================================
`timescale 1ns/1ps

module rr_arbiter #(
    parameter int num_clients = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [num_clients-1:0] valid_candidate,
    output logic [num_clients-1:0] winner_dec_id     // One-hot or zero
);

    localparam int idx_w = (num_clients > 1) ? $clog2(num_clients) : 1;

    logic [idx_w-1:0] ptr;          // Highest priority client this cycle
    logic [idx_w-1:0] grant_idx;    // Index of the winner
    logic             found;        // Some candidate won

    // ======================================================================
    // Search from the pointer, wrapping past the last client
    // ======================================================================
    always_comb begin
        int idx;
        winner_dec_id = '0;
        grant_idx     = '0;
        found         = 1'b0;
        for (int off = 0; off < num_clients; off++) begin
            idx = (int'(ptr) + off) % num_clients;
            if (!found && valid_candidate[idx]) begin
                found              = 1'b1;   // First hit wins
                winner_dec_id[idx] = 1'b1;
                grant_idx          = idx_w'(idx);
            end
        end
    end

    // Winner drops to lowest priority for the next round
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (found) begin
            if (grant_idx == idx_w'(num_clients - 1)) begin
                ptr <= '0;                  // Wrap after the top client
            end else begin
                ptr <= grant_idx + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/xy_route.sv ====
// ==========================================================================
// Dimension ordered XY routing only. X is resolved before Y
// ==========================================================================
`timescale 1ns/1ps

module xy_route #(
    parameter mesh_pkg::t_coord next_x = '0,   // Tile this port feeds
    parameter mesh_pkg::t_coord next_y = '0
) (
    input  logic                    in_valid,
    input  router_pkg::t_tile_trans in_trans,
    output logic                    route_valid,
    output router_pkg::t_tile_trans route_trans
);

    assign route_valid = in_valid;              // No storage in this stage

    // Direction the transaction takes when it leaves the next tile
    always_comb begin
        route_trans = in_trans;                 // Other fields pass as they are
        if (in_trans.dest_x > next_x) begin
            route_trans.next_tile_fifo_arb_id = mesh_pkg::dir_east;
        end else if (in_trans.dest_x < next_x) begin
            route_trans.next_tile_fifo_arb_id = mesh_pkg::dir_west;
        end else if (in_trans.dest_y > next_y) begin
            // Column reached, now move along Y
            route_trans.next_tile_fifo_arb_id = mesh_pkg::dir_north;
        end else if (in_trans.dest_y < next_y) begin
            route_trans.next_tile_fifo_arb_id = mesh_pkg::dir_south;
        end else begin
            route_trans.next_tile_fifo_arb_id = mesh_pkg::dir_local;  // Arrived
        end
    end

endmodule

// ==== verilog/fifo_arb.sv ====
// ==========================================================================
// Readiness is folded into arbitration so the output never stalls
// A blocked head holds its own FIFO only
// ==========================================================================
`timescale 1ns/1ps

module fifo_arb #(
    parameter int num_clients = 4,
    parameter int fifo_depth  = 4
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    // ==================== From the route stages ====================
    input  logic [num_clients-1:0]                  valid_alloc_req,
    input  router_pkg::t_tile_trans [num_clients-1:0] alloc_req,
    output logic [num_clients-1:0]                  out_ready_fifo,
    // ==================== Toward the neighbour tile ====================
    output router_pkg::t_tile_trans                 winner_req,
    output logic                                    winner_req_valid,
    input  logic                                    in_ready_north_arb_fifo,
    input  logic                                    in_ready_east_arb_fifo,
    input  logic                                    in_ready_south_arb_fifo,
    input  logic                                    in_ready_west_arb_fifo,
    input  logic                                    in_ready_local_arb_fifo
);

    localparam int trans_w = router_pkg::trans_w;

    router_pkg::t_tile_trans [num_clients-1:0] dout_fifo;   // FIFO heads
    logic [num_clients-1:0] push;
    logic [num_clients-1:0] fifo_pop;
    logic [num_clients-1:0] full;
    logic [num_clients-1:0] empty;
    logic [num_clients-1:0] dir_ready;          // Head direction can accept
    logic [num_clients-1:0] valid_candidate;
    logic [num_clients-1:0] winner_dec_id;
    logic [trans_w-1:0]     mux_bits;

    assign push           = valid_alloc_req;    // Plain strobe push
    assign out_ready_fifo = ~full;

    // One FIFO per input
    for (genvar i = 0; i < num_clients; i++) begin : gen_fifo
        tile_fifo #(
            .data_w (trans_w),
            .depth  (fifo_depth)
        ) u_tile_fifo (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (push[i]),
            .push_data (alloc_req[i]),
            .pop       (fifo_pop[i]),       // Popped only when granted
            .pop_data  (dout_fifo[i]),
            .full      (full[i]),
            .empty     (empty[i])
        );
    end

    // ======================================================================
    // Candidates need data and a ready direction
    // ======================================================================
    always_comb begin
        for (int i = 0; i < num_clients; i++) begin
            case (dout_fifo[i].next_tile_fifo_arb_id)
                mesh_pkg::dir_north: dir_ready[i] = in_ready_north_arb_fifo;
                mesh_pkg::dir_east:  dir_ready[i] = in_ready_east_arb_fifo;
                mesh_pkg::dir_south: dir_ready[i] = in_ready_south_arb_fifo;
                mesh_pkg::dir_west:  dir_ready[i] = in_ready_west_arb_fifo;
                mesh_pkg::dir_local: dir_ready[i] = in_ready_local_arb_fifo;
                default:             dir_ready[i] = 1'b0;   // Unused encodings
            endcase
            valid_candidate[i] = !empty[i] && dir_ready[i];
        end
    end

    rr_arbiter #(
        .num_clients (num_clients)
    ) u_rr_arbiter (
        .clk             (clk),
        .rst_n           (rst_n),
        .valid_candidate (valid_candidate),
        .winner_dec_id   (winner_dec_id)
    );

    assign fifo_pop         = winner_dec_id;    // Grant pops the winner
    assign winner_req_valid = |winner_dec_id;

    // AND-OR mux over the heads, grant is one-hot
    always_comb begin
        mux_bits = '0;
        for (int i = 0; i < num_clients; i++) begin
            mux_bits = mux_bits | (dout_fifo[i] & {trans_w{winner_dec_id[i]}});
        end
    end

    assign winner_req = router_pkg::t_tile_trans'(mux_bits);

endmodule

// ==== verilog/north_port.sv ====
// ==========================================================================
// Four inputs are wired explicitly so num_clients must stay at 4
// Senders must hold valid low while their out_ready is low
// ==========================================================================
`timescale 1ns/1ps

module north_port #(
    parameter int               num_clients = 4,
    parameter int               fifo_depth  = 4,
    parameter mesh_pkg::t_coord next_x      = '0,   // Neighbour tile position
    parameter mesh_pkg::t_coord next_y      = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    // ==================== Inputs east, south, west, local ====================
    input  logic                    in_valid_0,
    input  router_pkg::t_tile_trans in_trans_0,
    output logic                    out_ready_0,
    input  logic                    in_valid_1,
    input  router_pkg::t_tile_trans in_trans_1,
    output logic                    out_ready_1,
    input  logic                    in_valid_2,
    input  router_pkg::t_tile_trans in_trans_2,
    output logic                    out_ready_2,
    input  logic                    in_valid_3,
    input  router_pkg::t_tile_trans in_trans_3,
    output logic                    out_ready_3,
    // Neighbour tile readiness per direction
    input  logic                    ready_north,
    input  logic                    ready_east,
    input  logic                    ready_south,
    input  logic                    ready_west,
    input  logic                    ready_local,
    // ==================== Port output ====================
    output router_pkg::t_tile_trans winner_req,
    output logic                    winner_req_valid
);

    logic [num_clients-1:0]                    route_valid;
    router_pkg::t_tile_trans [num_clients-1:0] route_trans;

    // Route stages, one per input
    xy_route #(.next_x(next_x), .next_y(next_y)) u_xy_route_0 (
        .in_valid (in_valid_0), .in_trans (in_trans_0),
        .route_valid (route_valid[0]), .route_trans (route_trans[0])
    );
    xy_route #(.next_x(next_x), .next_y(next_y)) u_xy_route_1 (
        .in_valid (in_valid_1), .in_trans (in_trans_1),
        .route_valid (route_valid[1]), .route_trans (route_trans[1])
    );
    xy_route #(.next_x(next_x), .next_y(next_y)) u_xy_route_2 (
        .in_valid (in_valid_2), .in_trans (in_trans_2),
        .route_valid (route_valid[2]), .route_trans (route_trans[2])
    );
    xy_route #(.next_x(next_x), .next_y(next_y)) u_xy_route_3 (
        .in_valid (in_valid_3), .in_trans (in_trans_3),
        .route_valid (route_valid[3]), .route_trans (route_trans[3])
    );

    fifo_arb #(
        .num_clients (num_clients),
        .fifo_depth  (fifo_depth)
    ) u_fifo_arb (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .valid_alloc_req         (route_valid),
        .alloc_req               (route_trans),
        .out_ready_fifo          ({out_ready_3, out_ready_2, out_ready_1, out_ready_0}),
        .winner_req              (winner_req),
        .winner_req_valid        (winner_req_valid),
        .in_ready_north_arb_fifo (ready_north),
        .in_ready_east_arb_fifo  (ready_east),
        .in_ready_south_arb_fifo (ready_south),
        .in_ready_west_arb_fifo  (ready_west),
        .in_ready_local_arb_fifo (ready_local)
    );

endmodule

// ==== testbench/north_port_props.sv ====
// ==========================================================================
// Bound into fifo_arb. Checks pop, grant and push legality per FIFO
// ==========================================================================
`timescale 1ns/1ps

module north_port_props #(
    parameter int num_clients = 4
) (
    input logic                   clk,
    input logic                   rst_n,
    input logic [num_clients-1:0] push,
    input logic [num_clients-1:0] full,
    input logic [num_clients-1:0] fifo_pop,
    input logic [num_clients-1:0] empty,
    input logic                   winner_req_valid
);

    // A transfer on the port drains exactly one FIFO
    assert property (@(posedge clk) disable iff (!rst_n) winner_req_valid |-> $onehot(fifo_pop))
        else $error("Port transfer did not pop exactly one FIFO");

    // Grant must only reach a FIFO with data
    assert property (@(posedge clk) disable iff (!rst_n) (fifo_pop & empty) == '0)
        else $error("Grant given to an empty FIFO");

    // Push into full is lost unless the same FIFO pops
    assert property (@(posedge clk) disable iff (!rst_n) (push & full & ~fifo_pop) == '0)
        else $error("Push dropped at a full FIFO");

endmodule

bind fifo_arb north_port_props #(.num_clients(num_clients)) u_north_port_props (
    .clk (clk), .rst_n (rst_n), .push (push), .full (full),
    .fifo_pop (fifo_pop), .empty (empty), .winner_req_valid (winner_req_valid)
);

// ==== testbench/tb_north_port.sv ====
// ==========================================================================
// Case file runs one line per clock and must be read from the project root
// ==========================================================================
`timescale 1ns/1ps

module tb_north_port;

    localparam int    max_cycles = 200;                     // Case loop limit
    localparam string case_file  = "testbench/north_port_cases.txt";

    logic clk, rst_n;
    logic in_valid_0, in_valid_1, in_valid_2, in_valid_3;
    router_pkg::t_tile_trans in_trans_0, in_trans_1, in_trans_2, in_trans_3;
    logic out_ready_0, out_ready_1, out_ready_2, out_ready_3;
    logic ready_north, ready_east, ready_south, ready_west, ready_local;
    router_pkg::t_tile_trans winner_req;
    logic winner_req_valid;

    // ======================================================================
    // Fields of the current case line
    // ======================================================================
    logic                         v_in   [4];
    logic [router_pkg::tag_w-1:0] tag_in [4];
    mesh_pkg::t_coord             x_in   [4];
    mesh_pkg::t_coord             y_in   [4];
    logic [4:0]                   rdy_in;       // N E S W L, north in the MSB
    logic                         exp_valid;
    logic [router_pkg::tag_w-1:0] exp_tag;
    logic [2:0]                   exp_dir;
    logic [3:0]                   exp_ready;    // out_ready_3 down to out_ready_0

    // Destination of every sent transaction, indexed by its tag
    mesh_pkg::t_coord             sent_x [256];
    mesh_pkg::t_coord             sent_y [256];

    north_port #(
        .num_clients (4),
        .fifo_depth  (4),
        .next_x      (2'd1),
        .next_y      (2'd1)
    ) u_north_port (
        .clk (clk), .rst_n (rst_n),
        .in_valid_0 (in_valid_0), .in_trans_0 (in_trans_0), .out_ready_0 (out_ready_0),
        .in_valid_1 (in_valid_1), .in_trans_1 (in_trans_1), .out_ready_1 (out_ready_1),
        .in_valid_2 (in_valid_2), .in_trans_2 (in_trans_2), .out_ready_2 (out_ready_2),
        .in_valid_3 (in_valid_3), .in_trans_3 (in_trans_3), .out_ready_3 (out_ready_3),
        .ready_north (ready_north), .ready_east (ready_east), .ready_south (ready_south),
        .ready_west (ready_west), .ready_local (ready_local),
        .winner_req (winner_req), .winner_req_valid (winner_req_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                 // 20 ns period
    end

    // Payload is tied to the tag so a swapped payload shows up
    function automatic logic [router_pkg::payload_w-1:0] payload_for(
        input logic [router_pkg::tag_w-1:0] tag);
        return {~tag, tag};
    endfunction

    function automatic router_pkg::t_tile_trans make_trans(
        input logic [router_pkg::tag_w-1:0] tag, input mesh_pkg::t_coord x,
        input mesh_pkg::t_coord y);
        router_pkg::t_tile_trans t;
        t.tag                   = tag;
        t.dest_x                = x;
        t.dest_y                = y;
        t.next_tile_fifo_arb_id = mesh_pkg::dir_west;   // Stale, route stage overwrites
        t.payload               = payload_for(tag);
        return t;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("Mismatch at %0t: %s got %0h, expected %0h",
                                        $time, name, got, expected));
        end
    endtask

    task automatic drive_case();
        in_valid_0  = v_in[0];
        in_trans_0  = make_trans(tag_in[0], x_in[0], y_in[0]);
        in_valid_1  = v_in[1];
        in_trans_1  = make_trans(tag_in[1], x_in[1], y_in[1]);
        in_valid_2  = v_in[2];
        in_trans_2  = make_trans(tag_in[2], x_in[2], y_in[2]);
        in_valid_3  = v_in[3];
        in_trans_3  = make_trans(tag_in[3], x_in[3], y_in[3]);
        ready_north = rdy_in[4];
        ready_east  = rdy_in[3];
        ready_south = rdy_in[2];
        ready_west  = rdy_in[1];
        ready_local = rdy_in[0];
        for (int k = 0; k < 4; k++) begin
            if (v_in[k]) begin                  // Remember where this tag was sent
                sent_x[tag_in[k]] = x_in[k];
                sent_y[tag_in[k]] = y_in[k];
            end
        end
    endtask

    task automatic check_case();
        check_value("winner_req_valid", 32'(winner_req_valid), 32'(exp_valid));
        if (exp_valid) begin                    // Data only matters on a transfer
            check_value("winner_req.tag", 32'(winner_req.tag), 32'(exp_tag));
            check_value("winner_req.next_tile_fifo_arb_id",
                        32'(winner_req.next_tile_fifo_arb_id), 32'(exp_dir));
            check_value("winner_req.payload", 32'(winner_req.payload),
                        32'(payload_for(exp_tag)));
            check_value("winner_req.dest_x", 32'(winner_req.dest_x),
                        32'(sent_x[exp_tag]));
            check_value("winner_req.dest_y", 32'(winner_req.dest_y),
                        32'(sent_y[exp_tag]));
        end
        check_value("out_ready", 32'({out_ready_3, out_ready_2, out_ready_1, out_ready_0}),
                    32'(exp_ready));
    endtask

    // ======================================================================
    // Reset, then one case line per cycle until end of file
    // ======================================================================
    initial begin : run_cases
        int    fd;
        int    code;
        int    cycles;
        string line;
        logic  done;
        rst_n = 1'b0;
        {in_valid_0, in_valid_1, in_valid_2, in_valid_3} = '0;
        {in_trans_0, in_trans_1, in_trans_2, in_trans_3} = '0;
        {ready_north, ready_east, ready_south, ready_west, ready_local} = '1;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
        end
        #1 rst_n = 1'b1;
        fd = $fopen(case_file, "r");
        if (fd == 0) begin
            stop_with_failure("Could not open the case file");
        end
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            if (cycles >= max_cycles) begin
                stop_with_failure("Timed out before reaching the end of the case file");
            end
            code = $fgets(line, fd);
            if (code == 0) begin
                done = 1'b1;                    // End of file
            end else if (line.len() > 0 && line[0] != "#" && line[0] != "\n") begin
                code = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %b %h %h %h %b",
                    v_in[0], tag_in[0], x_in[0], y_in[0], v_in[1], tag_in[1], x_in[1],
                    y_in[1], v_in[2], tag_in[2], x_in[2], y_in[2], v_in[3], tag_in[3],
                    x_in[3], y_in[3], rdy_in, exp_valid, exp_tag, exp_dir, exp_ready);
                if (code != 21) begin
                    stop_with_failure($sformatf("Case line could not be parsed: %s", line));
                end
                @(posedge clk);
                #1 drive_case();
                #17 check_case();               // 2 ns before the next edge
                cycles++;
            end
        end
        $fclose(fd);
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== testbench/north_port_cases.txt ====
# in0..in3 each as: valid tag dest_x dest_y (hex), then readies N E S W L (binary)
# expected: valid tag dir (0=N 1=E 2=S 3=W 4=L) out_ready[3:0] (binary)
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  11111  0 00 0 1111
# single transactions, one per direction
1 10 3 1  0 00 0 0  0 00 0 0  0 00 0 0  11111  0 00 0 1111
1 11 1 1  0 00 0 0  0 00 0 0  0 00 0 0  11111  1 10 1 1111
1 12 1 3  0 00 0 0  0 00 0 0  0 00 0 0  11111  1 11 4 1111
0 00 0 0  0 00 0 0  0 00 0 0  1 13 1 0  11111  1 12 0 1111
# two rounds on all four inputs
1 20 2 1  1 21 0 1  1 22 1 2  1 23 1 1  11111  1 13 2 1111
1 30 3 3  1 31 0 0  1 32 1 3  1 33 1 0  11111  1 20 1 1111
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  11111  1 21 3 1111
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  11111  1 22 0 1111
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  11111  1 23 4 1111
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  11111  1 30 1 1111
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  11111  1 31 3 1111
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  11111  1 32 0 1111
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  11111  1 33 2 1111
# east blocked, other inputs pass
1 40 3 2  1 41 1 1  0 00 0 0  0 00 0 0  10111  0 00 0 1111
0 00 0 0  0 00 0 0  1 42 0 2  0 00 0 0  10111  1 41 4 1111
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  10111  1 42 3 1111
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  11111  1 40 1 1111
# fill input 2 with north blocked, then drain in order
0 00 0 0  0 00 0 0  1 50 1 3  0 00 0 0  01111  0 00 0 1111
0 00 0 0  0 00 0 0  1 51 1 3  0 00 0 0  01111  0 00 0 1111
0 00 0 0  0 00 0 0  1 52 1 3  0 00 0 0  01111  0 00 0 1111
0 00 0 0  0 00 0 0  1 53 1 3  0 00 0 0  01111  0 00 0 1111
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  01111  0 00 0 1011
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  11111  1 50 0 1011
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  11111  1 51 0 1111
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  11111  1 52 0 1111
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  11111  1 53 0 1111
0 00 0 0  0 00 0 0  0 00 0 0  0 00 0 0  11111  0 00 0 1111

// ==== compile.f ====
verilog/mesh_pkg.sv
verilog/router_pkg.sv
verilog/tile_fifo.sv
verilog/rr_arbiter.sv
verilog/xy_route.sv
verilog/fifo_arb.sv
verilog/north_port.sv
testbench/north_port_props.sv
testbench/tb_north_port.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the north port testbench with Verilator, result taken from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_north_port -o sim_north_port
./obj_dir/sim_north_port 2>&1 | tee sim.log || true

if grep -qx "Finished with no errors" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
